//--- Bender.yml
package:
  name: mdu_pipeline

sources:
  - files:
      - design/mduPkg.sv
      - design/mulPipe.sv
      - design/divPipe.sv
      - design/resultQueue.sv
      - design/mduControl.sv
      - design/mduTop.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/mduTb.sv

//--- design/divPipe.sv
`timescale 1ns/100ps

module divPipe (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               opSigned,
    input  mduPkg::word_t      a,
    input  mduPkg::word_t      b,
    input  mduPkg::robId_t     robId,
    input  mduPkg::pReg_t      dstHi,
    input  mduPkg::pReg_t      dstLo,
    output logic               outValid,
    output mduPkg::divEntry_t  outEntry
);

    logic           aNeg;
    logic           bNeg;

    logic [mduPkg::DIV_STEPS:0] validPipe;

    // Partial remainder and the dividend bits that turn into quotient bits.
    mduPkg::word_t  remPipe    [1:mduPkg::DIV_STEPS];
    mduPkg::word_t  dvdPipe    [0:mduPkg::DIV_STEPS];
    mduPkg::word_t  dvsPipe    [0:mduPkg::DIV_STEPS-1];
    logic           remNegPipe [0:mduPkg::DIV_STEPS];
    logic           quoNegPipe [0:mduPkg::DIV_STEPS];
    logic           zeroPipe   [0:mduPkg::DIV_STEPS];
    mduPkg::robId_t robIdPipe  [0:mduPkg::DIV_STEPS];
    mduPkg::pReg_t  dstHiPipe  [0:mduPkg::DIV_STEPS];
    mduPkg::pReg_t  dstLoPipe  [0:mduPkg::DIV_STEPS];

    assign aNeg = opSigned & a[mduPkg::WORD_W-1];
    assign bNeg = opSigned & b[mduPkg::WORD_W-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
            outValid  <= 1'b0;
        end else begin
            validPipe <= {validPipe[mduPkg::DIV_STEPS-1:0], start};
            outValid  <= validPipe[mduPkg::DIV_STEPS];
        end
    end

    // ------------------------------------------------------------
    // Input stage.
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        dvdPipe[0]    <= aNeg ? -a : a;
        dvsPipe[0]    <= bNeg ? -b : b;
        remNegPipe[0] <= aNeg;
        quoNegPipe[0] <= aNeg ^ bNeg;
        zeroPipe[0]   <= (b == '0);
        robIdPipe[0]  <= robId;
        dstHiPipe[0]  <= dstHi;
        dstLoPipe[0]  <= dstLo;
    end

    // ------------------------------------------------------------
    // Restoring steps, one quotient bit each.
    // ------------------------------------------------------------
    for (genvar s = 1; s <= mduPkg::DIV_STEPS; s++) begin : g_step
        logic [mduPkg::WORD_W:0] trial;
        logic                    fits;

        // The partial remainder starts at zero.
        if (s == 1) begin : g_first
            assign trial = {{mduPkg::WORD_W{1'b0}}, dvdPipe[0][mduPkg::WORD_W-1]};
        end else begin : g_next
            assign trial = {remPipe[s-1], dvdPipe[s-1][mduPkg::WORD_W-1]};
        end
        assign fits  = trial >= {1'b0, dvsPipe[s-1]};

        always_ff @(posedge clk) begin
            remPipe[s]    <= fits ? trial[mduPkg::WORD_W-1:0] - dvsPipe[s-1]
                                  : trial[mduPkg::WORD_W-1:0];
            dvdPipe[s]    <= {dvdPipe[s-1][mduPkg::WORD_W-2:0], fits};
            remNegPipe[s] <= remNegPipe[s-1];
            quoNegPipe[s] <= quoNegPipe[s-1];
            zeroPipe[s]   <= zeroPipe[s-1];
            robIdPipe[s]  <= robIdPipe[s-1];
            dstHiPipe[s]  <= dstHiPipe[s-1];
            dstLoPipe[s]  <= dstLoPipe[s-1];
        end

        if (s < mduPkg::DIV_STEPS) begin : g_fwd
            always_ff @(posedge clk) begin
                dvsPipe[s] <= dvsPipe[s-1];
            end
        end
    end

    // Sign fix. A zero divisor leaves the dividend magnitude in the remainder.
    always_ff @(posedge clk) begin
        outEntry.robId     <= robIdPipe[mduPkg::DIV_STEPS];
        outEntry.dstHi     <= dstHiPipe[mduPkg::DIV_STEPS];
        outEntry.dstLo     <= dstLoPipe[mduPkg::DIV_STEPS];
        outEntry.remainder <= remNegPipe[mduPkg::DIV_STEPS] ? -remPipe[mduPkg::DIV_STEPS]
                                                            : remPipe[mduPkg::DIV_STEPS];
        if (zeroPipe[mduPkg::DIV_STEPS]) begin
            outEntry.quotient <= '1;
        end else if (quoNegPipe[mduPkg::DIV_STEPS]) begin
            outEntry.quotient <= -dvdPipe[mduPkg::DIV_STEPS];
        end else begin
            outEntry.quotient <= dvdPipe[mduPkg::DIV_STEPS];
        end
    end

endmodule

//--- design/mduControl.sv
`timescale 1ns/100ps

module mduControl (
    input  logic               clk,
    input  logic               rst,
    input  logic               issueValid,
    input  mduPkg::mduOp_e     issueOp,
    output logic               mulStart,
    output logic               divStart,
    output logic               opSigned,

    input  logic               mulHeadValid,
    input  mduPkg::mulEntry_t  mulHead,
    input  logic               divHeadValid,
    input  mduPkg::divEntry_t  divHead,
    output logic               mulPop,
    output logic               divPop,

    output logic               wbValid,
    output mduPkg::pReg_t      wbDst,
    output mduPkg::word_t      wbData,
    output logic               finishValid,
    output mduPkg::robId_t     finishRobId,
    output logic               mulCredit,
    output logic               divCredit
);

    typedef enum logic [2:0] {idle, mulHi, mulLo, divHi, divLo} state_e;

    state_e state;
    state_e nextState;
    logic   lastWasMul;
    logic   isMul;
    logic   mulReady;
    logic   divReady;

    // ------------------------------------------------------------
    // Issue decode.
    // ------------------------------------------------------------
    assign isMul    = (issueOp == mduPkg::MUL) || (issueOp == mduPkg::MULU);
    assign mulStart = issueValid && isMul;
    assign divStart = issueValid && !isMul;
    assign opSigned = (issueOp == mduPkg::MUL) || (issueOp == mduPkg::DIV);

    // ------------------------------------------------------------
    // Writeback sequencing.
    // ------------------------------------------------------------
    // A head in its own lo cycle is the entry being retired.
    assign mulReady = mulHeadValid && (state != mulLo);
    assign divReady = divHeadValid && (state != divLo);

    always_comb begin
        nextState = idle;
        case (state)
            mulHi: nextState = mulLo;
            divHi: nextState = divLo;
            default: begin
                if (mulReady && divReady) begin
                    nextState = lastWasMul ? divHi : mulHi;
                end else if (mulReady) begin
                    nextState = mulHi;
                end else if (divReady) begin
                    nextState = divHi;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            lastWasMul <= 1'b0;
        end else begin
            state <= nextState;
            if (nextState == mulHi) begin
                lastWasMul <= 1'b1;
            end else if (nextState == divHi) begin
                lastWasMul <= 1'b0;
            end
        end
    end

    always_comb begin
        wbValid     = 1'b1;
        wbDst       = mulHead.dstHi;
        wbData      = mulHead.product[2*mduPkg::WORD_W-1:mduPkg::WORD_W];
        finishRobId = mulHead.robId;
        case (state)
            idle: wbValid = 1'b0;
            mulLo: begin
                wbDst  = mulHead.dstLo;
                wbData = mulHead.product[mduPkg::WORD_W-1:0];
            end
            divHi: begin
                wbDst       = divHead.dstHi;
                wbData      = divHead.remainder;
                finishRobId = divHead.robId;
            end
            divLo: begin
                wbDst       = divHead.dstLo;
                wbData      = divHead.quotient;
                finishRobId = divHead.robId;
            end
            default: ;
        endcase
    end

    // The lo cycle retires the entry.
    assign finishValid = (state == mulLo) || (state == divLo);
    assign mulPop      = (state == mulLo);
    assign divPop      = (state == divLo);
    assign mulCredit   = mulPop;
    assign divCredit   = divPop;

endmodule

//--- design/mduPkg.sv
package mduPkg;

    // ------------------------------------------------------------
    // Widths and timing.
    // ------------------------------------------------------------
    localparam int WORD_W      = 32;
    localparam int ROB_ID_W    = 6;
    localparam int PREG_W      = 7;

    localparam int MUL_LAT     = 3;
    // Input stage, one stage per quotient bit, sign fix.
    localparam int DIV_LAT     = 34;
    localparam int DIV_STEPS   = DIV_LAT - 2;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // ------------------------------------------------------------
    // Types.
    // ------------------------------------------------------------
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [ROB_ID_W-1:0] robId_t;
    typedef logic [PREG_W-1:0]   pReg_t;

    typedef enum logic [1:0] {
        MUL  = 2'd0,
        MULU = 2'd1,
        DIV  = 2'd2,
        DIVU = 2'd3
    } mduOp_e;

    // Upper half of the product goes to hi.
    typedef struct packed {
        robId_t              robId;
        pReg_t               dstHi;
        pReg_t               dstLo;
        logic [2*WORD_W-1:0] product;
    } mulEntry_t;

    typedef struct packed {
        robId_t robId;
        pReg_t  dstHi;
        pReg_t  dstLo;
        word_t  remainder;
        word_t  quotient;
    } divEntry_t;

endpackage

//--- design/mduTop.sv
`timescale 1ns/100ps

module mduPipelineTop (
    input  logic            clk,
    input  logic            rst,
    input  logic            issueValid,
    input  mduPkg::mduOp_e  issueOp,
    input  mduPkg::word_t   issueA,
    input  mduPkg::word_t   issueB,
    input  mduPkg::robId_t  issueRobId,
    input  mduPkg::pReg_t   issueDstHi,
    input  mduPkg::pReg_t   issueDstLo,
    output logic            mulCredit,
    output logic            divCredit,
    output logic            wbValid,
    output mduPkg::pReg_t   wbDst,
    output mduPkg::word_t   wbData,
    output logic            finishValid,
    output mduPkg::robId_t  finishRobId
);

    logic               mulStart;
    logic               divStart;
    logic               opSigned;

    logic               mulOutValid;
    mduPkg::mulEntry_t  mulOutEntry;
    logic               divOutValid;
    mduPkg::divEntry_t  divOutEntry;

    logic               mulHeadValid;
    mduPkg::mulEntry_t  mulHead;
    logic               mulPop;
    logic               divHeadValid;
    mduPkg::divEntry_t  divHead;
    logic               divPop;

    mduControl u_mduControl (
        .clk          (clk),
        .rst          (rst),
        .issueValid   (issueValid),
        .issueOp      (issueOp),
        .mulStart     (mulStart),
        .divStart     (divStart),
        .opSigned     (opSigned),
        .mulHeadValid (mulHeadValid),
        .mulHead      (mulHead),
        .divHeadValid (divHeadValid),
        .divHead      (divHead),
        .mulPop       (mulPop),
        .divPop       (divPop),
        .wbValid      (wbValid),
        .wbDst        (wbDst),
        .wbData       (wbData),
        .finishValid  (finishValid),
        .finishRobId  (finishRobId),
        .mulCredit    (mulCredit),
        .divCredit    (divCredit)
    );

    // ------------------------------------------------------------
    // Multiply path.
    // ------------------------------------------------------------
    mulPipe u_mulPipe (
        .clk      (clk),
        .rst      (rst),
        .start    (mulStart),
        .opSigned (opSigned),
        .a        (issueA),
        .b        (issueB),
        .robId    (issueRobId),
        .dstHi    (issueDstHi),
        .dstLo    (issueDstLo),
        .outValid (mulOutValid),
        .outEntry (mulOutEntry)
    );

    resultQueue #(.entry_t(mduPkg::mulEntry_t)) u_mulQueue (
        .clk       (clk),
        .rst       (rst),
        .push      (mulOutValid),
        .pushEntry (mulOutEntry),
        .pop       (mulPop),
        .headValid (mulHeadValid),
        .head      (mulHead)
    );

    // ------------------------------------------------------------
    // Divide path.
    // ------------------------------------------------------------
    divPipe u_divPipe (
        .clk      (clk),
        .rst      (rst),
        .start    (divStart),
        .opSigned (opSigned),
        .a        (issueA),
        .b        (issueB),
        .robId    (issueRobId),
        .dstHi    (issueDstHi),
        .dstLo    (issueDstLo),
        .outValid (divOutValid),
        .outEntry (divOutEntry)
    );

    resultQueue #(.entry_t(mduPkg::divEntry_t)) u_divQueue (
        .clk       (clk),
        .rst       (rst),
        .push      (divOutValid),
        .pushEntry (divOutEntry),
        .pop       (divPop),
        .headValid (divHeadValid),
        .head      (divHead)
    );

endmodule

//--- design/mulPipe.sv
`timescale 1ns/100ps

module mulPipe (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               opSigned,
    input  mduPkg::word_t      a,
    input  mduPkg::word_t      b,
    input  mduPkg::robId_t     robId,
    input  mduPkg::pReg_t      dstHi,
    input  mduPkg::pReg_t      dstLo,
    output logic               outValid,
    output mduPkg::mulEntry_t  outEntry
);

    logic [mduPkg::MUL_LAT:1]          validPipe;
    mduPkg::robId_t                    robIdPipe [1:mduPkg::MUL_LAT];
    mduPkg::pReg_t                     dstHiPipe [1:mduPkg::MUL_LAT];
    mduPkg::pReg_t                     dstLoPipe [1:mduPkg::MUL_LAT];

    // One extra bit so unsigned operands multiply as positive signed values.
    logic signed [mduPkg::WORD_W:0]     aExt;
    logic signed [mduPkg::WORD_W:0]     bExt;
    logic signed [2*mduPkg::WORD_W-1:0] prodPipe [2:mduPkg::MUL_LAT];

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[mduPkg::MUL_LAT-1:1], start};
        end
    end

    always_ff @(posedge clk) begin
        aExt         <= {opSigned & a[mduPkg::WORD_W-1], a};
        bExt         <= {opSigned & b[mduPkg::WORD_W-1], b};
        robIdPipe[1] <= robId;
        dstHiPipe[1] <= dstHi;
        dstLoPipe[1] <= dstLo;
        prodPipe[2]  <= aExt * bExt;
        for (int i = 2; i <= mduPkg::MUL_LAT; i++) begin
            robIdPipe[i] <= robIdPipe[i-1];
            dstHiPipe[i] <= dstHiPipe[i-1];
            dstLoPipe[i] <= dstLoPipe[i-1];
        end
        for (int i = 3; i <= mduPkg::MUL_LAT; i++) begin
            prodPipe[i] <= prodPipe[i-1];
        end
    end

    assign outValid         = validPipe[mduPkg::MUL_LAT];
    assign outEntry.robId   = robIdPipe[mduPkg::MUL_LAT];
    assign outEntry.dstHi   = dstHiPipe[mduPkg::MUL_LAT];
    assign outEntry.dstLo   = dstLoPipe[mduPkg::MUL_LAT];
    assign outEntry.product = prodPipe[mduPkg::MUL_LAT];

endmodule

//--- design/resultQueue.sv
`timescale 1ns/100ps

module resultQueue #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t pushEntry,
    input  logic   pop,
    output logic   headValid,
    output entry_t head
);

    entry_t                          mem [mduPkg::QUEUE_DEPTH];
    logic [mduPkg::QUEUE_PTR_W-1:0]  wrPtr;
    logic [mduPkg::QUEUE_PTR_W-1:0]  rdPtr;
    logic [mduPkg::QUEUE_CNT_W-1:0]  count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == mduPkg::QUEUE_PTR_W'(mduPkg::QUEUE_DEPTH - 1))
                         ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == mduPkg::QUEUE_PTR_W'(mduPkg::QUEUE_DEPTH - 1))
                         ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    assign headValid = (count != '0);
    assign head      = mem[rdPtr];

endmodule

//--- testbench/mduVectors.svh
`ifndef MDU_VECTORS_SVH
`define MDU_VECTORS_SVH

// Each row holds the operation, operand a, operand b, expected hi and expected lo.
// Divides carry the remainder in hi and the quotient in lo.
typedef struct packed {
    mduPkg::mduOp_e op;
    mduPkg::word_t  a;
    mduPkg::word_t  b;
    mduPkg::word_t  hi;
    mduPkg::word_t  lo;
} vector_t;

localparam int VEC_COUNT = 27;

vector_t vectors [VEC_COUNT];

task automatic loadVectors();
    vectors[0]  = '{mduPkg::MUL,  32'h00000000, 32'h12345678, 32'h00000000, 32'h00000000};
    vectors[1]  = '{mduPkg::MUL,  32'hffffffff, 32'hffffffff, 32'h00000000, 32'h00000001};
    vectors[2]  = '{mduPkg::MULU, 32'hffffffff, 32'hffffffff, 32'hfffffffe, 32'h00000001};
    vectors[3]  = '{mduPkg::MUL,  32'h80000000, 32'h80000000, 32'h40000000, 32'h00000000};
    vectors[4]  = '{mduPkg::MULU, 32'h80000000, 32'h00000002, 32'h00000001, 32'h00000000};
    vectors[5]  = '{mduPkg::MUL,  32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000};
    vectors[6]  = '{mduPkg::MUL,  32'hffffffff, 32'h00000007, 32'hffffffff, 32'hfffffff9};
    vectors[7]  = '{mduPkg::MULU, 32'hffffffff, 32'h00000007, 32'h00000006, 32'hfffffff9};
    vectors[8]  = '{mduPkg::MUL,  32'h7fffffff, 32'h7fffffff, 32'h3fffffff, 32'h00000001};
    vectors[9]  = '{mduPkg::MUL,  32'h7fffffff, 32'h80000000, 32'hc0000000, 32'h80000000};
    vectors[10] = '{mduPkg::MULU, 32'h0000ffff, 32'h0000ffff, 32'h00000000, 32'hfffe0001};
    vectors[11] = '{mduPkg::MULU, 32'h80000000, 32'h80000000, 32'h40000000, 32'h00000000};
    vectors[12] = '{mduPkg::MUL,  32'h80000000, 32'h00000001, 32'hffffffff, 32'h80000000};
    // Divides with mixed signs.
    vectors[13] = '{mduPkg::DIV,  32'h00000007, 32'h00000002, 32'h00000001, 32'h00000003};
    vectors[14] = '{mduPkg::DIV,  32'hfffffff9, 32'h00000002, 32'hffffffff, 32'hfffffffd};
    vectors[15] = '{mduPkg::DIV,  32'h00000007, 32'hfffffffe, 32'h00000001, 32'hfffffffd};
    vectors[16] = '{mduPkg::DIV,  32'hfffffff9, 32'hfffffffe, 32'hffffffff, 32'h00000003};
    vectors[17] = '{mduPkg::DIVU, 32'hfffffff9, 32'h00000002, 32'h00000001, 32'h7ffffffc};
    // Zero divisor.
    vectors[18] = '{mduPkg::DIV,  32'h00000064, 32'h00000000, 32'h00000064, 32'hffffffff};
    vectors[19] = '{mduPkg::DIV,  32'hffffff9c, 32'h00000000, 32'hffffff9c, 32'hffffffff};
    vectors[20] = '{mduPkg::DIVU, 32'h80000000, 32'h00000000, 32'h80000000, 32'hffffffff};
    // Most negative value by -1 overflows back to itself.
    vectors[21] = '{mduPkg::DIV,  32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000};
    vectors[22] = '{mduPkg::DIVU, 32'h80000000, 32'hffffffff, 32'h80000000, 32'h00000000};
    vectors[23] = '{mduPkg::DIV,  32'h80000000, 32'h00000002, 32'h00000000, 32'hc0000000};
    vectors[24] = '{mduPkg::DIVU, 32'hffffffff, 32'h00000010, 32'h0000000f, 32'h0fffffff};
    vectors[25] = '{mduPkg::DIV,  32'h00000000, 32'h00000005, 32'h00000000, 32'h00000000};
    vectors[26] = '{mduPkg::DIV,  32'h7fffffff, 32'h7fffffff, 32'h00000000, 32'h00000001};
endtask

`endif

//--- testbench/mduTb.sv
`timescale 1ns/100ps

module mduTb;

    localparam int BURST_COUNT  = 10;
    localparam int RANDOM_COUNT = 200;
    localparam int ID_COUNT     = 2 ** mduPkg::ROB_ID_W;

    logic               clk;
    logic               rst;
    logic               issueValid;
    mduPkg::mduOp_e     issueOp;
    mduPkg::word_t      issueA;
    mduPkg::word_t      issueB;
    mduPkg::robId_t     issueRobId;
    mduPkg::pReg_t      issueDstHi;
    mduPkg::pReg_t      issueDstLo;
    logic               mulCredit;
    logic               divCredit;
    logic               wbValid;
    mduPkg::pReg_t      wbDst;
    mduPkg::word_t      wbData;
    logic               finishValid;
    mduPkg::robId_t     finishRobId;

    `include "mduVectors.svh"

    localparam int TIMEOUT_CYCLES =
        (VEC_COUNT + 2 * BURST_COUNT + RANDOM_COUNT) * (mduPkg::DIV_LAT + 4) + 200;

    // Scoreboard indexed by robId.
    logic               pending  [ID_COUNT];
    mduPkg::word_t      expHi    [ID_COUNT];
    mduPkg::word_t      expLo    [ID_COUNT];
    mduPkg::pReg_t      expDstHi [ID_COUNT];
    mduPkg::pReg_t      expDstLo [ID_COUNT];
    mduPkg::robId_t     mulOrder [$];
    mduPkg::robId_t     divOrder [$];

    int                 mulCredits;
    int                 divCredits;
    int                 issuedCount;
    int                 finishedCount;
    int                 cycleCount;
    integer             seed;
    mduPkg::robId_t     nextId;
    mduPkg::robId_t     curId;
    logic               curIsMul;
    logic               inLo;

    mduPipelineTop u_mduPipelineTop (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .issueOp     (issueOp),
        .issueA      (issueA),
        .issueB      (issueB),
        .issueRobId  (issueRobId),
        .issueDstHi  (issueDstHi),
        .issueDstLo  (issueDstLo),
        .mulCredit   (mulCredit),
        .divCredit   (divCredit),
        .wbValid     (wbValid),
        .wbDst       (wbDst),
        .wbData      (wbData),
        .finishValid (finishValid),
        .finishRobId (finishRobId)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Checks.
    // ------------------------------------------------------------
    task automatic stopRun();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input mduPkg::word_t got,
                             input mduPkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkReg(input string name, input mduPkg::pReg_t got,
                            input mduPkg::pReg_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkRobId(input string name, input mduPkg::robId_t got,
                              input mduPkg::robId_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stopRun();
        end
    endtask

    // ------------------------------------------------------------
    // Reference model and issuer.
    // ------------------------------------------------------------
    task automatic computeExpected(input mduPkg::mduOp_e op, input mduPkg::word_t a,
                                   input mduPkg::word_t b, output mduPkg::word_t hi,
                                   output mduPkg::word_t lo);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] prod;
        int          sa;
        int          sb;
        logic        sgn;
        sgn = (op == mduPkg::MUL) || (op == mduPkg::DIV);
        sa  = a;
        sb  = b;
        if (op == mduPkg::MUL || op == mduPkg::MULU) begin
            ax   = sgn ? {{32{a[31]}}, a} : {32'h0, a};
            bx   = sgn ? {{32{b[31]}}, b} : {32'h0, b};
            prod = ax * bx;
            hi   = prod[63:32];
            lo   = prod[31:0];
        end else if (b == '0) begin
            hi = a;
            lo = '1;
        end else if (!sgn) begin
            hi = a % b;
            lo = a / b;
        end else if (a == 32'h80000000 && b == 32'hffffffff) begin
            hi = '0;
            lo = a;
        end else begin
            hi = sa % sb;
            lo = sa / sb;
        end
    endtask

    // Mostly random words with some zero, overflow and small divisors mixed in.
    task automatic pickOperands(output mduPkg::word_t a, output mduPkg::word_t b);
        int pick;
        a    = $random(seed);
        b    = $random(seed);
        pick = $random(seed) & 7;
        if (pick == 0) begin
            b = '0;
        end else if (pick == 1) begin
            a = 32'h80000000;
            b = '1;
        end else if (pick == 2) begin
            b = b & 32'hff;
        end else if (pick == 3) begin
            b = b >> 20;
        end
    endtask

    task automatic sendOp(input mduPkg::mduOp_e op, input mduPkg::word_t a,
                          input mduPkg::word_t b, input mduPkg::word_t hi,
                          input mduPkg::word_t lo);
        logic isMul;
        isMul = (op == mduPkg::MUL) || (op == mduPkg::MULU);
        @(posedge clk);
        while ((isMul ? mulCredits : divCredits) == 0) begin
            issueValid <= 1'b0;
            @(posedge clk);
        end
        while (pending[nextId]) begin
            nextId = nextId + 1'b1;
        end
        issueValid <= 1'b1;
        issueOp    <= op;
        issueA     <= a;
        issueB     <= b;
        issueRobId <= nextId;
        issueDstHi <= {nextId, 1'b0};
        issueDstLo <= {nextId, 1'b1};
        pending[nextId]  = 1'b1;
        expHi[nextId]    = hi;
        expLo[nextId]    = lo;
        expDstHi[nextId] = {nextId, 1'b0};
        expDstLo[nextId] = {nextId, 1'b1};
        if (isMul) begin
            mulCredits--;
            mulOrder.push_back(nextId);
        end else begin
            divCredits--;
            divOrder.push_back(nextId);
        end
        issuedCount++;
        nextId = nextId + 1'b1;
    endtask

    task automatic endIssue();
        @(posedge clk);
        issueValid <= 1'b0;
    endtask

    task automatic waitDrain();
        while (issuedCount != finishedCount) begin
            @(posedge clk);
        end
    endtask

    // ------------------------------------------------------------
    // Writeback monitor on the falling edge.
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (!inLo) begin
                checkBit("finishValid", finishValid, 1'b0);
                checkBit("mulCredit", mulCredit, 1'b0);
                checkBit("divCredit", divCredit, 1'b0);
                if (wbValid) begin
                    if (mulOrder.size() > 0 && wbDst === expDstHi[mulOrder[0]]) begin
                        curId    = mulOrder[0];
                        curIsMul = 1'b1;
                    end else if (divOrder.size() > 0 && wbDst === expDstHi[divOrder[0]]) begin
                        curId    = divOrder[0];
                        curIsMul = 1'b0;
                    end else begin
                        $display("ERROR at %0t ns: hi writeback to register %h matches no head",
                                 $time, wbDst);
                        stopRun();
                    end
                    checkWord("wbData", wbData, expHi[curId]);
                    inLo = 1'b1;
                end
            end else begin
                checkBit("wbValid", wbValid, 1'b1);
                checkReg("wbDst", wbDst, expDstLo[curId]);
                checkWord("wbData", wbData, expLo[curId]);
                checkBit("finishValid", finishValid, 1'b1);
                checkRobId("finishRobId", finishRobId, curId);
                checkBit("mulCredit", mulCredit, curIsMul);
                checkBit("divCredit", divCredit, !curIsMul);
                pending[curId] = 1'b0;
                finishedCount++;
                if (curIsMul) begin
                    mulOrder.delete(0);
                end else begin
                    divOrder.delete(0);
                end
                inLo = 1'b0;
            end
            if (mulCredit) begin
                mulCredits++;
            end
            if (divCredit) begin
                divCredits++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("ERROR at %0t ns: operations still pending after %0d cycles",
                     $time, TIMEOUT_CYCLES);
            stopRun();
        end
    end

    // ------------------------------------------------------------
    // Test sequence.
    // ------------------------------------------------------------
    initial begin : mainSeq
        mduPkg::mduOp_e op;
        mduPkg::word_t  a;
        mduPkg::word_t  b;
        mduPkg::word_t  hi;
        mduPkg::word_t  lo;
        rst           = 1'b1;
        issueValid    = 1'b0;
        issueOp       = mduPkg::MUL;
        issueA        = '0;
        issueB        = '0;
        issueRobId    = '0;
        issueDstHi    = '0;
        issueDstLo    = '0;
        seed          = 32'hc4218128;
        mulCredits    = mduPkg::QUEUE_DEPTH;
        divCredits    = mduPkg::QUEUE_DEPTH;
        issuedCount   = 0;
        finishedCount = 0;
        cycleCount    = 0;
        nextId        = '0;
        curId         = '0;
        curIsMul      = 1'b0;
        inLo          = 1'b0;
        for (int i = 0; i < ID_COUNT; i++) begin
            pending[i] = 1'b0;
        end
        loadVectors();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Idle cycles; the monitor flags any writeback or credit here.
        repeat (4) @(posedge clk);

        for (int i = 0; i < VEC_COUNT; i++) begin
            sendOp(vectors[i].op, vectors[i].a, vectors[i].b, vectors[i].hi, vectors[i].lo);
        end
        endIssue();
        waitDrain();

        // Back-to-back burst that runs both credit counters dry.
        for (int i = 0; i < 2 * BURST_COUNT; i++) begin
            if (i < BURST_COUNT) begin
                op = ($random(seed) & 1) ? mduPkg::MULU : mduPkg::MUL;
            end else begin
                op = ($random(seed) & 1) ? mduPkg::DIVU : mduPkg::DIV;
            end
            pickOperands(a, b);
            computeExpected(op, a, b, hi, lo);
            sendOp(op, a, b, hi, lo);
        end
        endIssue();
        waitDrain();

        for (int i = 0; i < RANDOM_COUNT; i++) begin
            op = mduPkg::mduOp_e'(2'($random(seed) & 3));
            pickOperands(a, b);
            computeExpected(op, a, b, hi, lo);
            sendOp(op, a, b, hi, lo);
        end
        endIssue();
        waitDrain();
        repeat (4) @(posedge clk);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+testbench
design/mduPkg.sv
design/mulPipe.sv
design/divPipe.sv
design/resultQueue.sv
design/mduControl.sv
design/mduTop.sv
testbench/mduTb.sv
